/* all.f */
+incdir+testbench
common/mult_pkg.sv
multiplier/mult_feeder.sv
multiplier/mult_row_stage.sv
multiplier/mult_drain.sv
source/mult_top.sv
testbench/tb_mult_top.sv

/* Makefile */
# Verilator build and run for the pipelined multiplier.

.PHONY: compile run clean

compile:
	verilator --binary --timing -Mdir obj_dir --top-module tb_mult_top \
		-f all.f -o tb_mult_top

run: compile
	@out="$$(./obj_dir/tb_mult_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* testbench/tb_mult_checks.svh */
`ifndef TB_MULT_CHECKS_SVH
`define TB_MULT_CHECKS_SVH

// ----------------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------------
task automatic check_res(input string name, input mult_pkg::res_t got,
                         input mult_pkg::res_t exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("FAIL t=%0t %s got %h expected %h",
                                    $time, name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("FAIL t=%0t %s got %b expected %b",
                                    $time, name, got, exp));
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        stop_with_failure($sformatf("FAIL t=%0t %s got %0d expected %0d",
                                    $time, name, got, exp));
    end
endtask

// ----------------------------------------------------------------------------
// reference model and random source
// ----------------------------------------------------------------------------
// full signed product of two operands.
function automatic mult_pkg::res_t ref_product(input logic signed [mult_pkg::OP_W-1:0] a,
                                               input logic signed [mult_pkg::OP_W-1:0] b);
    mult_pkg::res_t wide_a;
    mult_pkg::res_t wide_b;
    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

/* testbench/tb_mult_top.sv */
`timescale 1ns/1ps

module tb_mult_top;

    localparam int OUT_DEPTH    = 4;
    localparam int OUT_CREDITS  = 2;
    localparam int NUM_VEC      = 12;
    localparam int NUM_RAND     = 200;
    localparam int WAIT_LIMIT   = 500;
    // longer than the 33 cycle latency.
    localparam int QUIET_CYCLES = 40;

    typedef struct packed {
        logic signed [mult_pkg::OP_W-1:0] a;
        logic signed [mult_pkg::OP_W-1:0] b;
        mult_pkg::res_t                   prod;
    } vec_t;

    logic           clk = 1'b0;
    logic           arst_n;
    logic           op_valid;
    mult_pkg::op_t  op;
    logic           op_ready;
    logic           res_valid;
    mult_pkg::res_t res;
    logic           res_credit = 1'b0;

    mult_pkg::res_t exp_q [$];
    logic           credit_on = 1'b1;
    int             owed = 0;
    int             rx_count = 0;
    logic [31:0]    lcg_state;

    // each entry holds a, b and the expected product.
    vec_t vectors [NUM_VEC] = '{
        '{32'sh0000_0000, 32'sh0000_0000, 64'sh0000_0000_0000_0000},
        '{32'sh0000_0001, 32'sh0000_0001, 64'sh0000_0000_0000_0001},
        '{32'sh0000_0001, 32'shffff_ffff, 64'shffff_ffff_ffff_ffff},
        '{32'shffff_ffff, 32'shffff_ffff, 64'sh0000_0000_0000_0001},
        '{32'sh0000_0000, 32'sh7fff_ffff, 64'sh0000_0000_0000_0000},
        '{32'sh7fff_ffff, 32'sh7fff_ffff, 64'sh3fff_ffff_0000_0001},
        '{32'sh8000_0000, 32'sh8000_0000, 64'sh4000_0000_0000_0000},
        '{32'sh8000_0000, 32'shffff_ffff, 64'sh0000_0000_8000_0000},
        '{32'sh7fff_ffff, 32'sh8000_0000, 64'shc000_0000_8000_0000},
        '{32'sh0000_0003, 32'shffff_fffb, 64'shffff_ffff_ffff_fff1},
        '{32'shffff_fc18, 32'sh0000_03e8, 64'shffff_ffff_fff0_bdc0},
        '{32'sh0001_0000, 32'sh0001_0000, 64'sh0000_0001_0000_0000}
    };

    always #5 clk = ~clk;

    mult_top #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_mult_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (op_valid),
        .op         (op),
        .op_ready   (op_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    `include "tb_mult_checks.svh"

    // ------------------------------------------------------------------------
    // operand side
    // ------------------------------------------------------------------------
    task automatic send_op(input logic signed [31:0] a, input logic signed [31:0] b,
                           input mult_pkg::res_t expected);
        int waited;
        waited   = 0;
        op_valid = 1'b1;
        op.a     = a;
        op.b     = b;
        while (op_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("operand port never became ready");
            end
        end
        exp_q.push_back(expected);
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic send_random_pair();
        logic signed [31:0] a;
        logic signed [31:0] b;
        lcg_state = lcg_next(lcg_state);
        a         = lcg_state;
        lcg_state = lcg_next(lcg_state);
        b         = lcg_state;
        send_op(a, b, ref_product(a, b));
    endtask

    // ------------------------------------------------------------------------
    // waits
    // ------------------------------------------------------------------------
    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        @(posedge clk);
        while (exp_q.size() != 0 || owed != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure($sformatf("results of the %s never all arrived", what));
            end
        end
        @(negedge clk);
    endtask

    task automatic wait_results(input int base, input int n);
        int waited;
        waited = 0;
        @(posedge clk);
        while (rx_count - base < n) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("results covered by the initial credits never came out");
            end
        end
    endtask

    task automatic wait_op_ready();
        int waited;
        waited = 0;
        while (op_ready !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_with_failure("op_ready never rose after credits came back");
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // result side: scoreboard and credit return
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : monitor
        mult_pkg::res_t expected;
        if (arst_n === 1'b1 && res_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("a result came out with no operand outstanding");
            end
            expected = exp_q.pop_front();
            check_res("res", res, expected);
            rx_count++;
            owed++;
        end
        if (credit_on && owed > 0) begin
            res_credit = 1'b1;
            owed--;
        end else begin
            res_credit = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (20000) @(posedge clk);
        stop_with_failure("simulation ran past its cycle limit");
    end

    initial begin : stimulus
        int base;
        arst_n    = 1'b0;
        op_valid  = 1'b0;
        op        = '0;
        lcg_state = 32'd60840;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        check_bit("res_valid", res_valid, 1'b0);
        check_bit("op_ready", op_ready, 1'b1);

        for (int i = 0; i < NUM_VEC; i++) begin
            send_op(vectors[i].a, vectors[i].b, vectors[i].prod);
        end
        wait_idle("table");

        for (int i = 0; i < NUM_RAND; i++) begin
            send_random_pair();
        end
        wait_idle("random stream");

        // no credits returned. only the initial credits let results out.
        credit_on = 1'b0;
        base      = rx_count;
        for (int i = 0; i < OUT_DEPTH; i++) begin
            send_random_pair();
        end
        wait_results(base, OUT_CREDITS);
        repeat (QUIET_CYCLES) @(posedge clk);
        check_count("results without credit", rx_count - base, OUT_CREDITS);
        @(negedge clk);
        check_bit("op_ready", op_ready, 1'b1);

        // fill the drain buffer until the feeder runs dry.
        for (int i = 0; i < OUT_CREDITS; i++) begin
            send_random_pair();
        end
        repeat (3) begin
            check_bit("op_ready", op_ready, 1'b0);
            @(negedge clk);
        end

        credit_on = 1'b1;
        wait_op_ready();
        wait_idle("credit release");

        $display("sim passed");
        $finish;
    end

endmodule

/* source/mult_top.sv */
`timescale 1ns/1ps

module mult_top #(
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            op_valid,
    input  mult_pkg::op_t   op,
    output logic            op_ready,
    output logic            res_valid,
    output mult_pkg::res_t  res,
    input  logic            res_credit
);

    localparam int OP_W = mult_pkg::OP_W;

    // rows[0] comes from the feeder, rows[k] from stage k.
    mult_pkg::row_t rows [0:OP_W-1];
    logic           slot_free;

    mult_feeder #(
        .OUT_DEPTH (OUT_DEPTH)
    ) u_feeder (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op        (op),
        .op_ready  (op_ready),
        .slot_free (slot_free),
        .row_out   (rows[0])
    );

    // ------------------------------------------------------------------------
    // row stages 1 to 31
    // ------------------------------------------------------------------------
    for (genvar k = 1; k < OP_W; k++) begin : g_row
        mult_row_stage #(
            .ROW_IDX (k)
        ) u_stage (
            .clk     (clk),
            .arst_n  (arst_n),
            .row_in  (rows[k-1]),
            .row_out (rows[k])
        );
    end

    mult_drain #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_drain (
        .clk        (clk),
        .arst_n     (arst_n),
        .row_in     (rows[OP_W-1]),
        .slot_free  (slot_free),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

endmodule

/* multiplier/mult_drain.sv */
`timescale 1ns/1ps

module mult_drain #(
    parameter int OUT_DEPTH   = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mult_pkg::row_t  row_in,
    output logic            slot_free,
    output logic            res_valid,
    output mult_pkg::res_t  res,
    input  logic            res_credit
);

    localparam int OP_W   = mult_pkg::OP_W;
    localparam int PROD_W = mult_pkg::PROD_W;
    localparam int PTR_W  = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W  = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W  = $clog2(OUT_CREDITS + 1);

    // final baugh-wooley correction at the top bit.
    localparam logic [PROD_W-1:0] CORR = {1'b1, {(PROD_W-1){1'b0}}};

    mult_pkg::res_t     mem [OUT_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRD_W-1:0]   credits;
    logic [PROD_W-1:0]  raw;
    mult_pkg::res_t     product;
    logic               wr_en;
    logic               send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(OUT_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // product assembly
    // ------------------------------------------------------------------------
    // low[0] never received a product bit.
    assign raw     = {row_in.sum, row_in.low[OP_W-1:1]};
    assign product = raw + CORR;
    assign wr_en   = row_in.valid;

    // ------------------------------------------------------------------------
    // result buffer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= product;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (wr_en && !send) begin
                count <= count + 1'b1;
            end else if (!wr_en && send) begin
                count <= count - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // result port, external credits
    // ------------------------------------------------------------------------
    assign send      = (count != '0) && (credits != '0);
    assign res_valid = send;
    assign res       = mem[rd_ptr];
    assign slot_free = send;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else if (send && !res_credit) begin
            credits <= credits - 1'b1;
        end else if (!send && res_credit) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

/* multiplier/mult_row_stage.sv */
`timescale 1ns/1ps

module mult_row_stage #(
    parameter int ROW_IDX = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  mult_pkg::row_t  row_in,
    output mult_pkg::row_t  row_out
);

    localparam int  OP_W     = mult_pkg::OP_W;
    localparam bit  SIGN_ROW = (ROW_IDX == OP_W - 1);

    // the b-sign row inverts everything but the top term.
    // other rows invert only the a-sign term.
    localparam logic [OP_W-1:0] INV_MASK = SIGN_ROW ? {1'b0, {(OP_W-1){1'b1}}}
                                                    : {1'b1, {(OP_W-1){1'b0}}};

    logic [OP_W-1:0] pp;
    logic [OP_W:0]   shifted;
    mult_pkg::row_t  row_d;

    // ------------------------------------------------------------------------
    // partial product of this row
    // ------------------------------------------------------------------------
    assign pp = (row_in.a & {OP_W{row_in.b[ROW_IDX]}}) ^ INV_MASK;

    // drop the finished bit and align with this row's weight.
    assign shifted = {1'b0, row_in.sum[OP_W:1]};

    // ------------------------------------------------------------------------
    // accumulate and retire one product bit
    // ------------------------------------------------------------------------
    always_comb begin
        row_d.valid = row_in.valid;
        row_d.a     = row_in.a;
        row_d.b     = row_in.b;
        row_d.sum   = shifted + {1'b0, pp};
        row_d.low   = {row_in.sum[0], row_in.low[OP_W-1:1]};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_out.valid <= 1'b0;
        end else begin
            row_out <= row_d;
        end
    end

endmodule

/* multiplier/mult_feeder.sv */
`timescale 1ns/1ps

module mult_feeder #(
    parameter int OUT_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            op_valid,
    input  mult_pkg::op_t   op,
    output logic            op_ready,
    input  logic            slot_free,
    output mult_pkg::row_t  row_out
);

    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    // inverts the a-sign term of row 0.
    localparam logic [mult_pkg::OP_W-1:0] SIGN_MASK = {1'b1, {(mult_pkg::OP_W-1){1'b0}}};

    logic [CNT_W-1:0]          credits;
    logic                      accept;
    logic [mult_pkg::OP_W-1:0] pp0;
    mult_pkg::row_t            row_d;

    assign op_ready = (credits != '0);
    assign accept   = op_valid && op_ready;

    // ------------------------------------------------------------------------
    // internal credits, one per drain buffer slot
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CNT_W'(OUT_DEPTH);
        end else if (accept && !slot_free) begin
            credits <= credits - 1'b1;
        end else if (!accept && slot_free) begin
            credits <= credits + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // row 0
    // ------------------------------------------------------------------------
    assign pp0 = (op.a & {mult_pkg::OP_W{op.b[0]}}) ^ SIGN_MASK;

    always_comb begin
        row_d.valid = accept;
        row_d.a     = op.a;
        row_d.b     = op.b;
        // baugh-wooley constant one above the sign term.
        row_d.sum   = {1'b1, pp0};
        row_d.low   = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_out.valid <= 1'b0;
        end else begin
            row_out <= row_d;
        end
    end

endmodule

/* common/mult_pkg.sv */
package mult_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int OP_W   = 32;
    localparam int PROD_W = 2 * OP_W;

    // ------------------------------------------------------------------------
    // payload types
    // ------------------------------------------------------------------------

    // operand pair at the input port.
    typedef struct packed {
        logic signed [OP_W-1:0] a;
        logic signed [OP_W-1:0] b;
    } op_t;

    // one slot of the row pipeline.
    // sum holds the running partial sum plus its carry.
    // low collects the finished product bits, newest at the top.
    typedef struct packed {
        logic                   valid;
        logic signed [OP_W-1:0] a;
        logic signed [OP_W-1:0] b;
        logic [OP_W:0]          sum;
        logic [OP_W-1:0]        low;
    } row_t;

    // signed product at the result port.
    typedef logic signed [PROD_W-1:0] res_t;

endpackage
